//--- common/cache_pkg.sv
// Geometry of the snoop-side data cache.
// Shared by the cache array and the snoop stages. Modules import it by
// wildcard inside their bodies and use scoped names in port lists.
package cache_pkg;

  // snoop and fill address width
  localparam int unsigned ADDR_WIDTH = 32;

  // 16-byte lines
  localparam int unsigned BYTE_OFFSET = 4;

  // sixteen sets
  localparam int unsigned INDEX_WIDTH = 4;
  localparam int unsigned NUM_SETS = 2 ** INDEX_WIDTH;

  // everything above index and offset
  localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - BYTE_OFFSET;

  // two ways, with a round-robin pointer per set
  localparam int unsigned SET_ASSOC = 2;
  localparam int unsigned WAY_WIDTH = $clog2(SET_ASSOC);

  localparam int unsigned LINE_WIDTH = 128;

  // a line leaves on CD as two beats
  localparam int unsigned BEAT_WIDTH = 64;

endpackage

//--- common/snoop_pkg.sv
// Snoop channel definitions.
// Holds the AC snoop kinds, the decoded operation handed from decode to
// execute, and the layout of the CR response bits.
package snoop_pkg;

  // AC snoop kinds, ACE encoding; the last two are not supported here
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_INVALID = 4'b1001,
    CLEAN_SHARED  = 4'b1000,
    MAKE_INVALID  = 4'b1101
  } acsnoop_e;

  typedef enum logic [2:0] {
    OP_READ_ONCE     = 3'd0,
    OP_READ_SHARED   = 3'd1,
    OP_READ_UNIQUE   = 3'd2,
    OP_CLEAN_INVALID = 3'd3,
    OP_ERROR         = 3'd4,
    OP_BYPASS        = 3'd5
  } snoop_op_e;

  // CR response; bit 4 is wasUnique and always stays 0
  localparam int unsigned CRRESP_WIDTH = 5;
  localparam int unsigned CR_DATA_TRANSFER = 0;
  localparam int unsigned CR_ERROR = 1;
  localparam int unsigned CR_PASS_DIRTY = 2;
  localparam int unsigned CR_IS_SHARED = 3;

endpackage

//--- snoop_ctrl/snoop_decode.sv
// Snoop decode stage.
// Accepts AC requests into a one-entry register, splits the address into
// index and tag and maps the snoop kind onto an execute operation.
`timescale 1ns/10ps

module snoop_decode (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                bypass_i,
  input  logic                                ac_valid_i,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    ac_addr_i,
  input  snoop_pkg::acsnoop_e                 ac_snoop_i,
  output logic                                ac_ready_o,
  output logic                                dec_valid_o,
  output snoop_pkg::snoop_op_e                dec_op_o,
  output logic [cache_pkg::INDEX_WIDTH-1:0]   dec_index_o,
  output logic [cache_pkg::TAG_WIDTH-1:0]     dec_tag_o,
  input  logic                                exe_ready_i
);
  import cache_pkg::*;
  import snoop_pkg::*;

  logic      valid_q;
  logic      accept;
  snoop_op_e op_d;

  // free now, or emptied by execute this cycle
  assign ac_ready_o = !valid_q || exe_ready_i;
  assign accept = ac_valid_i && ac_ready_o;
  assign dec_valid_o = valid_q;

  always_comb begin
    case (ac_snoop_i)
      READ_ONCE:     op_d = OP_READ_ONCE;
      READ_SHARED:   op_d = OP_READ_SHARED;
      READ_UNIQUE:   op_d = OP_READ_UNIQUE;
      CLEAN_INVALID: op_d = OP_CLEAN_INVALID;
      default:       op_d = OP_ERROR;
    endcase
    // disabled cache answers everything as a miss
    if (bypass_i) begin
      op_d = OP_BYPASS;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (exe_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_op_o    <= op_d;
      dec_index_o <= ac_addr_i[BYTE_OFFSET +: INDEX_WIDTH];
      dec_tag_o   <= ac_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
    end
  end

endmodule

//--- snoop_ctrl/snoop_execute.sv
// Snoop execute stage.
// Requests the cache array, evaluates the hit line's flags, builds the CR
// response and writes back the new coherence state. Error and bypass
// operations skip the array and answer at once.
`timescale 1ns/10ps

module snoop_execute (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 dec_valid_i,
  input  snoop_pkg::snoop_op_e                 dec_op_i,
  input  logic [cache_pkg::INDEX_WIDTH-1:0]    dec_index_i,
  input  logic [cache_pkg::TAG_WIDTH-1:0]      dec_tag_i,
  output logic                                 exe_ready_o,
  output logic                                 arr_req_o,
  input  logic                                 arr_gnt_i,
  output logic [cache_pkg::INDEX_WIDTH-1:0]    arr_index_o,
  output logic [cache_pkg::TAG_WIDTH-1:0]      arr_tag_o,
  input  logic [cache_pkg::SET_ASSOC-1:0]      hit_way_i,
  input  logic [cache_pkg::SET_ASSOC-1:0]      dirty_way_i,
  input  logic [cache_pkg::SET_ASSOC-1:0]      shared_way_i,
  input  logic [cache_pkg::LINE_WIDTH-1:0]     line_i,
  output logic                                 arr_we_o,
  output logic [cache_pkg::SET_ASSOC-1:0]      arr_wway_o,
  output logic                                 arr_wvalid_o,
  output logic                                 arr_wdirty_o,
  output logic                                 arr_wshared_o,
  output logic                                 res_valid_o,
  output logic [snoop_pkg::CRRESP_WIDTH-1:0]   res_resp_o,
  output logic [cache_pkg::LINE_WIDTH-1:0]     res_line_o,
  input  logic                                 res_ready_i,
  output logic                                 clean_invalid_hit_o,
  output logic                                 clean_invalid_miss_o
);
  import cache_pkg::*;
  import snoop_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    EVAL_FLAGS,
    WRITE_STATE,
    WAIT_RESULT
  } state_e;

  state_e                  state_q, state_d;
  logic [CRRESP_WIDTH-1:0] resp_q, resp_d;
  snoop_op_e               op_q;
  logic [SET_ASSOC-1:0]    way_q;
  logic                    dirty_q;
  logic                    hit, dirty, shared;
  logic                    is_read_shared;

  assign hit = |hit_way_i;
  assign dirty = |(hit_way_i & dirty_way_i);
  assign shared = |(hit_way_i & shared_way_i);
  assign is_read_shared = (op_q == OP_READ_SHARED);

  assign exe_ready_o = (state_q == IDLE);
  // held from grant until the state write, so no fill slips in between
  assign arr_req_o = (state_q == WAIT_GNT) || (state_q == EVAL_FLAGS) ||
                     (state_q == WRITE_STATE);

  // read shared keeps the line and its dirty bit, the rest invalidate
  assign arr_we_o = (state_q == WRITE_STATE);
  assign arr_wway_o = way_q;
  assign arr_wvalid_o = is_read_shared;
  assign arr_wdirty_o = is_read_shared && dirty_q;
  assign arr_wshared_o = is_read_shared;

  assign res_valid_o = (state_q == WAIT_RESULT);
  assign res_resp_o = resp_q;

  always_comb begin
    state_d = state_q;
    resp_d = resp_q;
    clean_invalid_hit_o = 1'b0;
    clean_invalid_miss_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (dec_valid_i) begin
          resp_d = '0;
          if (dec_op_i == OP_ERROR) begin
            resp_d[CR_ERROR] = 1'b1;
            state_d = WAIT_RESULT;
          end else if (dec_op_i == OP_BYPASS) begin
            state_d = WAIT_RESULT;
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end
      WAIT_GNT: begin
        if (arr_gnt_i) begin
          state_d = EVAL_FLAGS;
        end
      end
      EVAL_FLAGS: begin
        state_d = WAIT_RESULT;
        if (hit) begin
          resp_d[CR_DATA_TRANSFER] = 1'b1;
          case (op_q)
            OP_READ_ONCE: begin
              resp_d[CR_IS_SHARED] = shared;
            end
            OP_READ_SHARED: begin
              resp_d[CR_IS_SHARED] = 1'b1;
              state_d = WRITE_STATE;
            end
            OP_READ_UNIQUE: begin
              resp_d[CR_PASS_DIRTY] = dirty;
              state_d = WRITE_STATE;
            end
            default: begin
              // clean invalid only moves data when it is dirty
              resp_d[CR_DATA_TRANSFER] = dirty;
              resp_d[CR_PASS_DIRTY] = dirty;
              clean_invalid_hit_o = 1'b1;
              state_d = WRITE_STATE;
            end
          endcase
        end else begin
          clean_invalid_miss_o = (op_q == OP_CLEAN_INVALID);
        end
      end
      WRITE_STATE: begin
        state_d = WAIT_RESULT;
      end
      WAIT_RESULT: begin
        if (res_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      resp_q <= '0;
    end else begin
      state_q <= state_d;
      resp_q <= resp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && dec_valid_i) begin
      op_q <= dec_op_i;
      arr_index_o <= dec_index_i;
      arr_tag_o <= dec_tag_i;
    end
    // capture the hit line while the array still shows it
    if (state_q == EVAL_FLAGS) begin
      way_q <= hit_way_i;
      dirty_q <= dirty;
      res_line_o <= line_i;
    end
  end

endmodule

//--- snoop_ctrl/snoop_result.sv
// Snoop result stage.
// Registers one response, presents it on CR and, when data is returned,
// sends the line on CD as two beats, low half first. The stage frees
// itself once every required transfer has happened.
`timescale 1ns/10ps

module snoop_result (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 res_valid_i,
  input  logic [snoop_pkg::CRRESP_WIDTH-1:0]   res_resp_i,
  input  logic [cache_pkg::LINE_WIDTH-1:0]     res_line_i,
  output logic                                 res_ready_o,
  output logic                                 cr_valid_o,
  output logic [snoop_pkg::CRRESP_WIDTH-1:0]   cr_resp_o,
  input  logic                                 cr_ready_i,
  output logic                                 cd_valid_o,
  output logic [cache_pkg::BEAT_WIDTH-1:0]     cd_data_o,
  output logic                                 cd_last_o,
  input  logic                                 cd_ready_i
);
  import cache_pkg::*;
  import snoop_pkg::*;

  logic                  busy_q;
  logic                  cr_done_q;
  logic                  cd_done_q;
  logic                  beat_q;
  logic [LINE_WIDTH-1:0] line_q;
  logic                  cr_fire, cd_fire;
  logic                  cr_end, cd_end;

  assign res_ready_o = !busy_q;

  assign cr_valid_o = busy_q && !cr_done_q;
  assign cd_valid_o = busy_q && !cd_done_q;
  assign cd_data_o = beat_q ? line_q[LINE_WIDTH-1 -: BEAT_WIDTH] : line_q[BEAT_WIDTH-1:0];
  assign cd_last_o = beat_q;

  assign cr_fire = cr_valid_o && cr_ready_i;
  assign cd_fire = cd_valid_o && cd_ready_i;
  // channel finished earlier or finishing now
  assign cr_end = cr_done_q || cr_fire;
  assign cd_end = cd_done_q || (cd_fire && beat_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cr_done_q <= 1'b0;
      cd_done_q <= 1'b0;
      beat_q <= 1'b0;
    end else if (!busy_q) begin
      if (res_valid_i) begin
        busy_q <= 1'b1;
        cr_done_q <= 1'b0;
        // no data, nothing to send on CD
        cd_done_q <= !res_resp_i[CR_DATA_TRANSFER];
        beat_q <= 1'b0;
      end
    end else if (cr_end && cd_end) begin
      busy_q <= 1'b0;
    end else begin
      cr_done_q <= cr_end;
      cd_done_q <= cd_end;
      if (cd_fire) begin
        beat_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_ready_o) begin
      cr_resp_o <= res_resp_i;
      line_q <= res_line_i;
    end
  end

endmodule

//--- design/cache_array.sv
// Two-way cache array with valid, dirty, shared, tag and data per line.
// A snoop requests the array and, once granted, holds it locked until it
// drops its request. Hit flags and the hit line follow the granted
// request one cycle later. Fills write whole lines while no snoop holds
// the lock.
`timescale 1ns/10ps

module cache_array (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                arr_req_i,
  output logic                                arr_gnt_o,
  input  logic [cache_pkg::INDEX_WIDTH-1:0]   arr_index_i,
  input  logic [cache_pkg::TAG_WIDTH-1:0]     arr_tag_i,
  output logic [cache_pkg::SET_ASSOC-1:0]     hit_way_o,
  output logic [cache_pkg::SET_ASSOC-1:0]     dirty_way_o,
  output logic [cache_pkg::SET_ASSOC-1:0]     shared_way_o,
  output logic [cache_pkg::LINE_WIDTH-1:0]    line_o,
  input  logic                                arr_we_i,
  input  logic [cache_pkg::SET_ASSOC-1:0]     arr_wway_i,
  input  logic                                arr_wvalid_i,
  input  logic                                arr_wdirty_i,
  input  logic                                arr_wshared_i,
  input  logic                                fill_valid_i,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    fill_addr_i,
  input  logic [cache_pkg::LINE_WIDTH-1:0]    fill_data_i,
  input  logic                                fill_dirty_i,
  input  logic                                fill_shared_i,
  output logic                                fill_ready_o
);
  import cache_pkg::*;

  logic [SET_ASSOC-1:0]   valid_q  [NUM_SETS];
  logic [SET_ASSOC-1:0]   dirty_q  [NUM_SETS];
  logic [SET_ASSOC-1:0]   shared_q [NUM_SETS];
  logic [WAY_WIDTH-1:0]   rr_q     [NUM_SETS];
  logic [TAG_WIDTH-1:0]   tag_q    [NUM_SETS][SET_ASSOC];
  logic [LINE_WIDTH-1:0]  data_q   [NUM_SETS][SET_ASSOC];

  logic                   lock_q;
  logic                   grant;
  logic [INDEX_WIDTH-1:0] idx_q;
  logic [TAG_WIDTH-1:0]   req_tag_q;
  logic [INDEX_WIDTH-1:0] fill_idx;
  logic [TAG_WIDTH-1:0]   fill_tag;
  logic                   fill_we;
  logic [WAY_WIDTH-1:0]   fill_way;
  logic                   use_rr;

  assign fill_idx = fill_addr_i[BYTE_OFFSET +: INDEX_WIDTH];
  assign fill_tag = fill_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

  // a fill in the same cycle wins, the snoop is granted after it
  assign fill_we = fill_valid_i && !lock_q;
  assign fill_ready_o = fill_we;
  assign grant = arr_req_i && !lock_q && !fill_we;

  // victim: matching tag, else lowest invalid way, else round robin
  always_comb begin
    fill_way = rr_q[fill_idx];
    use_rr = 1'b1;
    for (int w = SET_ASSOC - 1; w >= 0; w--) begin
      if (!valid_q[fill_idx][w]) begin
        fill_way = WAY_WIDTH'(w);
        use_rr = 1'b0;
      end
    end
    for (int w = SET_ASSOC - 1; w >= 0; w--) begin
      if (valid_q[fill_idx][w] && (tag_q[fill_idx][w] == fill_tag)) begin
        fill_way = WAY_WIDTH'(w);
        use_rr = 1'b0;
      end
    end
  end

  // lookup on the request registered at grant
  always_comb begin
    line_o = '0;
    for (int w = 0; w < SET_ASSOC; w++) begin
      hit_way_o[w] = valid_q[idx_q][w] && (tag_q[idx_q][w] == req_tag_q);
      dirty_way_o[w] = dirty_q[idx_q][w];
      shared_way_o[w] = shared_q[idx_q][w];
      if (hit_way_o[w]) begin
        line_o = line_o | data_q[idx_q][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr_gnt_o <= 1'b0;
      lock_q <= 1'b0;
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        shared_q[s] <= '0;
        rr_q[s] <= '0;
      end
    end else begin
      arr_gnt_o <= grant;
      lock_q <= grant || (lock_q && arr_req_i);
      if (fill_we) begin
        valid_q[fill_idx][fill_way] <= 1'b1;
        dirty_q[fill_idx][fill_way] <= fill_dirty_i;
        shared_q[fill_idx][fill_way] <= fill_shared_i;
        if (use_rr) begin
          rr_q[fill_idx] <= rr_q[fill_idx] + 1'b1;
        end
      end else if (arr_we_i) begin
        for (int w = 0; w < SET_ASSOC; w++) begin
          if (arr_wway_i[w]) begin
            valid_q[idx_q][w] <= arr_wvalid_i;
            dirty_q[idx_q][w] <= arr_wdirty_i;
            shared_q[idx_q][w] <= arr_wshared_i;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      idx_q <= arr_index_i;
      req_tag_q <= arr_tag_i;
    end
    if (fill_we) begin
      tag_q[fill_idx][fill_way] <= fill_tag;
      data_q[fill_idx][fill_way] <= fill_data_i;
    end
  end

endmodule

//--- design/snoop_cache_top.sv
// Top level of the snoop-side data cache.
// Chains the decode, execute and result stages and connects execute to
// the cache array, which also takes the fill port.
`timescale 1ns/10ps

module snoop_cache_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                bypass_i,
  input  logic                                ac_valid_i,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    ac_addr_i,
  input  snoop_pkg::acsnoop_e                 ac_snoop_i,
  output logic                                ac_ready_o,
  output logic                                cr_valid_o,
  output logic [snoop_pkg::CRRESP_WIDTH-1:0]  cr_resp_o,
  input  logic                                cr_ready_i,
  output logic                                cd_valid_o,
  output logic [cache_pkg::BEAT_WIDTH-1:0]    cd_data_o,
  output logic                                cd_last_o,
  input  logic                                cd_ready_i,
  input  logic                                fill_valid_i,
  input  logic [cache_pkg::ADDR_WIDTH-1:0]    fill_addr_i,
  input  logic [cache_pkg::LINE_WIDTH-1:0]    fill_data_i,
  input  logic                                fill_dirty_i,
  input  logic                                fill_shared_i,
  output logic                                fill_ready_o,
  output logic                                clean_invalid_hit_o,
  output logic                                clean_invalid_miss_o
);
  import cache_pkg::*;
  import snoop_pkg::*;

  // decode to execute
  logic                    dec_valid, exe_ready;
  snoop_op_e               dec_op;
  logic [INDEX_WIDTH-1:0]  dec_index;
  logic [TAG_WIDTH-1:0]    dec_tag;

  // execute to array
  logic                    arr_req, arr_gnt;
  logic [INDEX_WIDTH-1:0]  arr_index;
  logic [TAG_WIDTH-1:0]    arr_tag;
  logic [SET_ASSOC-1:0]    hit_way, dirty_way, shared_way;
  logic [LINE_WIDTH-1:0]   hit_line;
  logic                    arr_we, arr_wvalid, arr_wdirty, arr_wshared;
  logic [SET_ASSOC-1:0]    arr_wway;

  // execute to result
  logic                    res_valid, res_ready;
  logic [CRRESP_WIDTH-1:0] res_resp;
  logic [LINE_WIDTH-1:0]   res_line;

  snoop_decode u_decode (
    .clk_i, .rst_ni, .bypass_i,
    .ac_valid_i, .ac_addr_i, .ac_snoop_i, .ac_ready_o,
    .dec_valid_o (dec_valid), .dec_op_o (dec_op),
    .dec_index_o (dec_index), .dec_tag_o (dec_tag),
    .exe_ready_i (exe_ready)
  );

  snoop_execute u_execute (
    .clk_i, .rst_ni,
    .dec_valid_i (dec_valid), .dec_op_i (dec_op),
    .dec_index_i (dec_index), .dec_tag_i (dec_tag),
    .exe_ready_o (exe_ready),
    .arr_req_o (arr_req), .arr_gnt_i (arr_gnt),
    .arr_index_o (arr_index), .arr_tag_o (arr_tag),
    .hit_way_i (hit_way), .dirty_way_i (dirty_way), .shared_way_i (shared_way),
    .line_i (hit_line),
    .arr_we_o (arr_we), .arr_wway_o (arr_wway), .arr_wvalid_o (arr_wvalid),
    .arr_wdirty_o (arr_wdirty), .arr_wshared_o (arr_wshared),
    .res_valid_o (res_valid), .res_resp_o (res_resp), .res_line_o (res_line),
    .res_ready_i (res_ready),
    .clean_invalid_hit_o, .clean_invalid_miss_o
  );

  snoop_result u_result (
    .clk_i, .rst_ni,
    .res_valid_i (res_valid), .res_resp_i (res_resp), .res_line_i (res_line),
    .res_ready_o (res_ready),
    .cr_valid_o, .cr_resp_o, .cr_ready_i,
    .cd_valid_o, .cd_data_o, .cd_last_o, .cd_ready_i
  );

  cache_array u_array (
    .clk_i, .rst_ni,
    .arr_req_i (arr_req), .arr_gnt_o (arr_gnt),
    .arr_index_i (arr_index), .arr_tag_i (arr_tag),
    .hit_way_o (hit_way), .dirty_way_o (dirty_way), .shared_way_o (shared_way),
    .line_o (hit_line),
    .arr_we_i (arr_we), .arr_wway_i (arr_wway), .arr_wvalid_i (arr_wvalid),
    .arr_wdirty_i (arr_wdirty), .arr_wshared_i (arr_wshared),
    .fill_valid_i, .fill_addr_i, .fill_data_i,
    .fill_dirty_i, .fill_shared_i, .fill_ready_o
  );

endmodule

//--- verif/snoop_cache_tb.sv
// Testbench for the snoop-side data cache.
// Fills known lines through the fill port, then applies a table of snoops
// and checks CR bits, CD beats and the clean-invalid event pulses.
// CR and CD ready are driven from an LFSR to create back-pressure.
`timescale 1ns/10ps

module snoop_cache_tb;
  import cache_pkg::*;
  import snoop_pkg::*;

  localparam int TIMEOUT = 200;

  // CR response bits
  localparam logic [CRRESP_WIDTH-1:0] RSP_NONE = 5'b00000;
  localparam logic [CRRESP_WIDTH-1:0] RSP_DT = 5'b00001;
  localparam logic [CRRESP_WIDTH-1:0] RSP_ERR = 5'b00010;
  localparam logic [CRRESP_WIDTH-1:0] RSP_PD = 5'b00100;
  localparam logic [CRRESP_WIDTH-1:0] RSP_SH = 5'b01000;

  // line addresses with A and H sharing set 4
  localparam logic [ADDR_WIDTH-1:0] ADDR_A = 32'h0001_2340;
  localparam logic [ADDR_WIDTH-1:0] ADDR_H = 32'h0099_2340;
  localparam logic [ADDR_WIDTH-1:0] ADDR_B = 32'h0004_5650;
  localparam logic [ADDR_WIDTH-1:0] ADDR_C = 32'h0007_8960;
  localparam logic [ADDR_WIDTH-1:0] ADDR_E = 32'h000a_bc70;
  localparam logic [ADDR_WIDTH-1:0] ADDR_F = 32'h000d_ef80;
  localparam logic [ADDR_WIDTH-1:0] ADDR_G = 32'h0011_2290;

  // one table row holds a fill or a snoop with its expected answer
  typedef struct packed {
    logic                    is_fill;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [LINE_WIDTH-1:0]   data;
    logic                    dirty;
    logic                    shared;
    logic [3:0]              snoop;
    logic                    bypass;
    logic [CRRESP_WIDTH-1:0] exp_resp;
    logic                    exp_hit;
    logic                    exp_miss;
  } row_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    bypass_i;
  logic                    ac_valid_i;
  logic [ADDR_WIDTH-1:0]   ac_addr_i;
  acsnoop_e                ac_snoop_i;
  logic                    ac_ready_o;
  logic                    cr_valid_o;
  logic [CRRESP_WIDTH-1:0] cr_resp_o;
  logic                    cr_ready_i;
  logic                    cd_valid_o;
  logic [BEAT_WIDTH-1:0]   cd_data_o;
  logic                    cd_last_o;
  logic                    cd_ready_i;
  logic                    fill_valid_i;
  logic [ADDR_WIDTH-1:0]   fill_addr_i;
  logic [LINE_WIDTH-1:0]   fill_data_i;
  logic                    fill_dirty_i;
  logic                    fill_shared_i;
  logic                    fill_ready_o;
  logic                    clean_invalid_hit_o;
  logic                    clean_invalid_miss_o;

  row_t        table_q[$];
  logic [31:0] lfsr;

  snoop_cache_top uut (.*);

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                          $time, name, got, exp));
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // line contents built from the address and a generation number
  function automatic logic [LINE_WIDTH-1:0] line_data(input logic [31:0] addr,
                                                      input logic [7:0] gen);
    return {addr ^ {4{gen}}, ~addr, {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3,
            addr + {24'h0, gen}};
  endfunction

  task automatic fill_entry(input logic [31:0] addr, input logic dirty,
                            input logic shared, input logic [7:0] gen);
    row_t r;
    r = '0;
    r.is_fill = 1'b1;
    r.addr = addr;
    r.data = line_data(addr, gen);
    r.dirty = dirty;
    r.shared = shared;
    table_q.push_back(r);
  endtask

  task automatic snoop_entry(input logic [31:0] addr, input logic [3:0] snoop,
                             input logic bypass, input logic [4:0] resp,
                             input logic [7:0] gen, input logic hit, input logic miss);
    row_t r;
    r = '0;
    r.addr = addr;
    r.data = line_data(addr, gen);
    r.snoop = snoop;
    r.bypass = bypass;
    r.exp_resp = resp;
    r.exp_hit = hit;
    r.exp_miss = miss;
    table_q.push_back(r);
  endtask

  task automatic apply_fill(input row_t row);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    #2;
    fill_valid_i = 1'b1;
    fill_addr_i = row.addr;
    fill_data_i = row.data;
    fill_dirty_i = row.dirty;
    fill_shared_i = row.shared;
    @(negedge clk_i);
    while (!fill_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout: the fill port never took the line");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    fill_valid_i = 1'b0;
  endtask

  task automatic run_snoop(input row_t row);
    int cycles;
    int beats;
    int need_beats;
    int hits;
    int misses;
    logic cr_done;
    cycles = 0;
    beats = 0;
    hits = 0;
    misses = 0;
    cr_done = 1'b0;
    need_beats = row.exp_resp[0] ? 2 : 0;
    @(posedge clk_i);
    #2;
    ac_valid_i = 1'b1;
    ac_addr_i = row.addr;
    ac_snoop_i = acsnoop_e'(row.snoop);
    bypass_i = row.bypass;
    @(negedge clk_i);
    while (!ac_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout: the AC request was never accepted");
      end
      @(negedge clk_i);
    end
    cycles = 0;
    while (!cr_done || (beats < need_beats)) begin
      @(posedge clk_i);
      #2;
      ac_valid_i = 1'b0;
      bypass_i = 1'b0;
      lfsr = lfsr_step(lfsr);
      cr_ready_i = lfsr[0];
      lfsr = lfsr_step(lfsr);
      cd_ready_i = lfsr[0];
      @(negedge clk_i);
      if (clean_invalid_hit_o) begin
        hits++;
      end
      if (clean_invalid_miss_o) begin
        misses++;
      end
      if (cr_valid_o && cr_ready_i) begin
        if (cr_done) begin
          abort_run("a second CR response arrived for the same snoop");
        end else begin
          check_value("cr_resp_o", 128'(cr_resp_o), 128'(row.exp_resp));
          cr_done = 1'b1;
        end
      end
      if (cd_valid_o && cd_ready_i) begin
        if (beats >= need_beats) begin
          abort_run("a CD beat arrived that the response did not call for");
        end else begin
          check_value("cd_data_o", 128'(cd_data_o),
                      (beats == 0) ? 128'(row.data[63:0]) : 128'(row.data[127:64]));
          check_value("cd_last_o", 128'(cd_last_o), 128'(beats == 1));
          beats++;
        end
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout: the snoop response did not complete");
      end
    end
    check_value("clean_invalid_hit_o", 128'(hits), 128'(row.exp_hit));
    check_value("clean_invalid_miss_o", 128'(misses), 128'(row.exp_miss));
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    bypass_i = 1'b0;
    ac_valid_i = 1'b0;
    ac_addr_i = '0;
    ac_snoop_i = READ_ONCE;
    cr_ready_i = 1'b0;
    cd_ready_i = 1'b0;
    fill_valid_i = 1'b0;
    fill_addr_i = '0;
    fill_data_i = '0;
    fill_dirty_i = 1'b0;
    fill_shared_i = 1'b0;
    lfsr = 32'h32c;

    fill_entry(ADDR_A, 1'b0, 1'b1, 8'd1);
    fill_entry(ADDR_H, 1'b0, 1'b0, 8'd2);
    fill_entry(ADDR_B, 1'b1, 1'b0, 8'd3);
    fill_entry(ADDR_C, 1'b1, 1'b0, 8'd4);
    fill_entry(ADDR_E, 1'b0, 1'b0, 8'd5);
    fill_entry(ADDR_F, 1'b1, 1'b1, 8'd6);
    fill_entry(ADDR_G, 1'b0, 1'b0, 8'd7);
    // read once on both ways of set 4
    snoop_entry(ADDR_A, READ_ONCE, 1'b0, RSP_DT | RSP_SH, 8'd1, 1'b0, 1'b0);
    snoop_entry(ADDR_A, READ_ONCE, 1'b0, RSP_DT | RSP_SH, 8'd1, 1'b0, 1'b0);
    snoop_entry(ADDR_H, READ_ONCE, 1'b0, RSP_DT, 8'd2, 1'b0, 1'b0);
    // read shared keeps the dirty bit
    snoop_entry(ADDR_B, READ_SHARED, 1'b0, RSP_DT | RSP_SH, 8'd3, 1'b0, 1'b0);
    snoop_entry(ADDR_B, READ_ONCE, 1'b0, RSP_DT | RSP_SH, 8'd3, 1'b0, 1'b0);
    snoop_entry(ADDR_B, CLEAN_INVALID, 1'b0, RSP_DT | RSP_PD, 8'd3, 1'b1, 1'b0);
    // clean invalid on dirty and clean lines
    snoop_entry(ADDR_C, CLEAN_INVALID, 1'b0, RSP_DT | RSP_PD, 8'd4, 1'b1, 1'b0);
    snoop_entry(ADDR_C, READ_ONCE, 1'b0, RSP_NONE, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_C, CLEAN_INVALID, 1'b0, RSP_NONE, 8'd0, 1'b0, 1'b1);
    snoop_entry(ADDR_E, CLEAN_INVALID, 1'b0, RSP_NONE, 8'd0, 1'b1, 1'b0);
    snoop_entry(ADDR_E, READ_ONCE, 1'b0, RSP_NONE, 8'd0, 1'b0, 1'b0);
    // read unique hands over dirtiness and invalidates
    snoop_entry(ADDR_F, READ_UNIQUE, 1'b0, RSP_DT | RSP_PD, 8'd6, 1'b0, 1'b0);
    snoop_entry(ADDR_F, READ_ONCE, 1'b0, RSP_NONE, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_G, READ_UNIQUE, 1'b0, RSP_DT, 8'd7, 1'b0, 1'b0);
    snoop_entry(ADDR_G, READ_SHARED, 1'b0, RSP_NONE, 8'd0, 1'b0, 1'b0);
    // unsupported kinds and bypass
    snoop_entry(ADDR_A, CLEAN_SHARED, 1'b0, RSP_ERR, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_H, MAKE_INVALID, 1'b0, RSP_ERR, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_A, READ_ONCE, 1'b1, RSP_NONE, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_H, CLEAN_INVALID, 1'b1, RSP_NONE, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_A, CLEAN_SHARED, 1'b1, RSP_NONE, 8'd0, 1'b0, 1'b0);
    snoop_entry(ADDR_A, READ_ONCE, 1'b0, RSP_DT | RSP_SH, 8'd1, 1'b0, 1'b0);
    // refill reuses the way with the matching tag
    fill_entry(ADDR_A, 1'b1, 1'b0, 8'd8);
    snoop_entry(ADDR_A, READ_ONCE, 1'b0, RSP_DT, 8'd8, 1'b0, 1'b0);
    snoop_entry(ADDR_H, READ_ONCE, 1'b0, RSP_DT, 8'd2, 1'b0, 1'b0);
    snoop_entry(ADDR_A, READ_UNIQUE, 1'b0, RSP_DT | RSP_PD, 8'd8, 1'b0, 1'b0);

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("ac_ready_o", 128'(ac_ready_o), 128'(1'b1));
    check_value("cr_valid_o", 128'(cr_valid_o), 128'(1'b0));
    check_value("cd_valid_o", 128'(cd_valid_o), 128'(1'b0));
    check_value("fill_ready_o", 128'(fill_ready_o), 128'(1'b0));
    check_value("clean_invalid_hit_o", 128'(clean_invalid_hit_o), 128'(1'b0));
    check_value("clean_invalid_miss_o", 128'(clean_invalid_miss_o), 128'(1'b0));

    foreach (table_q[i]) begin
      if (table_q[i].is_fill) begin
        apply_fill(table_q[i]);
      end else begin
        run_snoop(table_q[i]);
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

//--- snoop_cache_top.f
common/cache_pkg.sv
common/snoop_pkg.sv
snoop_ctrl/snoop_decode.sv
snoop_ctrl/snoop_execute.sv
snoop_ctrl/snoop_result.sv
design/cache_array.sv
design/snoop_cache_top.sv
verif/snoop_cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the snoop cache testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" &&
verilator --binary --timing \
  --top-module snoop_cache_tb \
  -f snoop_cache_top.f \
  -o snoop_cache_sim &&
./obj_dir/snoop_cache_sim || exit 1
